// File: verilog/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// producer word and consumer byte widths
`define FIFO_WORD_W 32
`define FIFO_BYTE_W 8

// bytes per word, one RAM block per byte lane
`define FIFO_LANES 4

// word address gives 16 words of storage
`define FIFO_WADDR_W 4

// byte address, word address plus lane bits
`define FIFO_RADDR_W 6

// most credits the consumer may hold outstanding
`define FIFO_OUT_CREDIT_MAX 8

`endif

// File: verilog/fifo_pkg.sv
`include "fifo_consts.svh"

package fifo_pkg;

   // producer side word
   typedef logic [`FIFO_WORD_W-1:0] word_t;

   // consumer side byte
   typedef logic [`FIFO_BYTE_W-1:0] byte_t;

   // word address into the RAM
   typedef logic [`FIFO_WADDR_W-1:0] waddr_t;

   // byte address, upper bits word, lower bits lane
   typedef logic [`FIFO_RADDR_W-1:0] raddr_t;

   // counts 0 up to the full depth of 16 credits
   typedef logic [$clog2((1 << `FIFO_WADDR_W) + 1)-1:0] credit_cnt_t;

endpackage

// File: verilog/ram_port_if.sv
`timescale 1ns/100ps

interface ram_port_if import fifo_pkg::*; ();

   // write port, one full word per strobe
   logic   w_en;
   waddr_t w_addr;
   word_t  w_data;

   // read port, one byte per strobe
   logic   r_en;
   raddr_t r_addr;
   byte_t  r_data;

   // controller side issues both requests
   modport ctrl (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   // memory side returns read data
   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

// File: verilog/ram_2p.sv
`timescale 1ns/100ps

module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] ram [DEPTH];

   // synchronous write
   always_ff @(posedge clk) begin
      if (w_en) begin
         ram[w_addr] <= w_data;
      end
   end

   // registered read, holds until the next r_en
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= ram[r_addr];
      end
   end

endmodule

// File: verilog/ram_2p_asym.sv
`timescale 1ns/100ps
`include "fifo_consts.svh"

module ram_2p_asym import fifo_pkg::*; (
   input logic     clk,
   ram_port_if.mem mem
);

   // lane bits sit below the word address in r_addr
   localparam int LANE_W = `FIFO_RADDR_W - `FIFO_WADDR_W;

   // per-lane buses of the symmetric blocks
   byte_t  wr_data [`FIFO_LANES];
   byte_t  rd_data [`FIFO_LANES];
   waddr_t rd_word;

   // lane picked for the read in flight
   logic [LANE_W-1:0] lane_sel;

   // every lane reads the same word
   assign rd_word = mem.r_addr[`FIFO_RADDR_W-1 -: `FIFO_WADDR_W];

   genvar j;
   generate
      for (j = 0; j < `FIFO_LANES; j++) begin : g_lane

         // lane j takes byte j of the word
         assign wr_data[j] = mem.w_data[j*`FIFO_BYTE_W +: `FIFO_BYTE_W];

         ram_2p #(
            .DATA_W (`FIFO_BYTE_W),
            .ADDR_W (`FIFO_WADDR_W)
         ) u_ram (
            .clk    (clk),
            .w_en   (mem.w_en),
            .w_addr (mem.w_addr),
            .w_data (wr_data[j]),
            .r_en   (mem.r_en),
            .r_addr (rd_word),
            .r_data (rd_data[j])
         );

      end
   endgenerate

   // loaded with the read so the mux matches the block output
   always_ff @(posedge clk) begin
      if (mem.r_en) begin
         lane_sel <= mem.r_addr[LANE_W-1:0];
      end
   end

   // byte select
   assign mem.r_data = rd_data[lane_sel];

endmodule

// File: verilog/credit_fifo_ctrl.sv
`timescale 1ns/100ps
`include "fifo_consts.svh"

module credit_fifo_ctrl import fifo_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      in_valid,
   input  word_t     in_data,
   output logic      in_credit,
   input  logic      out_credit,
   output logic      out_valid,
   ram_port_if.ctrl  mem
);

   localparam int LANE_W = `FIFO_RADDR_W - `FIFO_WADDR_W;

   // credits owed to the producer right after reset
   localparam credit_cnt_t DEPTH_CREDITS = credit_cnt_t'(1 << `FIFO_WADDR_W);

   // pointers carry one wrap bit above the address
   logic [`FIFO_WADDR_W:0] wr_ptr;
   logic [`FIFO_RADDR_W:0] rd_ptr;
   logic [`FIFO_RADDR_W:0] bytes_waiting;

   credit_cnt_t out_cnt;
   credit_cnt_t pend_cnt;

   logic rd_go;
   logic word_done;
   logic credit_issue;

   // write pointer in byte units minus read pointer
   assign bytes_waiting = {wr_ptr, {LANE_W{1'b0}}} - rd_ptr;

   // read when a byte is waiting and the consumer has room
   assign rd_go = (bytes_waiting != '0) && (out_cnt != '0);

   // last lane of a word frees that word
   assign word_done = rd_go && (&rd_ptr[LANE_W-1:0]);

   // a freed word may go back straight away when nothing is pending
   assign credit_issue = (pend_cnt != '0) || word_done;

   // RAM requests
   assign mem.w_en   = in_valid;
   assign mem.w_addr = wr_ptr[`FIFO_WADDR_W-1:0];
   assign mem.w_data = in_data;
   assign mem.r_en   = rd_go;
   assign mem.r_addr = rd_ptr[`FIFO_RADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (in_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_go) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // consumer credits, up on out_credit and down per read
   always_ff @(posedge clk) begin
      if (reset) begin
         out_cnt <= '0;
      end else begin
         case ({out_credit, rd_go})
            2'b10:   out_cnt <= out_cnt + 1'b1;
            2'b01:   out_cnt <= out_cnt - 1'b1;
            default: out_cnt <= out_cnt;
         endcase
      end
   end

   // producer credits still owed, paid one per cycle
   // a word finished while paying leaves the count level
   always_ff @(posedge clk) begin
      if (reset) begin
         pend_cnt <= DEPTH_CREDITS;
      end else if (credit_issue && !word_done) begin
         pend_cnt <= pend_cnt - 1'b1;
      end
   end

   // out_valid lines up with the registered RAM read
   always_ff @(posedge clk) begin
      if (reset) begin
         in_credit <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         in_credit <= credit_issue;
         out_valid <= rd_go;
      end
   end

endmodule

// File: verilog/width_down_fifo.sv
`timescale 1ns/100ps

module width_down_fifo import fifo_pkg::*; (
   input  logic  clk,
   input  logic  reset,

   // producer side, one word per credit
   input  logic  in_valid,
   input  word_t in_data,
   output logic  in_credit,

   // consumer side, one byte per credit
   output logic  out_valid,
   output byte_t out_data,
   input  logic  out_credit
);

   ram_port_if mem_bus ();

   // pointers and credit counters
   credit_fifo_ctrl u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .mem        (mem_bus.ctrl)
   );

   // word in, byte out storage
   ram_2p_asym u_ram (
      .clk (clk),
      .mem (mem_bus.mem)
   );

   assign out_data = mem_bus.r_data;

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // released just after an edge, like the other inputs
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

// File: verif/tb_checker.sv
`timescale 1ns/100ps
`include "fifo_consts.svh"

module tb_checker import fifo_pkg::*; (
   input logic  clk,
   input logic  reset,
   input logic  in_valid,
   input word_t in_data,
   input logic  in_credit,
   input logic  out_credit,
   input logic  out_valid,
   input byte_t out_data
);

   localparam int DEPTH_WORDS = 1 << `FIFO_WADDR_W;

   // bytes owed to the consumer, oldest first
   byte_t exp_q [$];
   byte_t exp_byte;
   int    lane;

   int words_in       = 0;
   int bytes_out      = 0;
   int in_credit_cnt  = 0;
   int out_credit_cnt = 0;
   int check_cnt      = 0;
   int err_cnt        = 0;
   int tests_done     = 0;
   int test_err_base  = 0;

   always @(posedge clk) begin
      if (!reset) begin
         if (in_credit) begin
            in_credit_cnt++;
         end
         if (out_credit) begin
            out_credit_cnt++;
         end
         // lowest byte of each word goes out first
         if (in_valid) begin
            words_in++;
            for (lane = 0; lane < `FIFO_LANES; lane++) begin
               exp_q.push_back(in_data[lane*`FIFO_BYTE_W +: `FIFO_BYTE_W]);
            end
         end
         if (out_valid) begin
            bytes_out++;
            check_cnt++;
            if (exp_q.size() == 0) begin
               err_cnt++;
               $display("ERROR at %0t: byte %02h arrived with no word pending",
                        $time, out_data);
            end else begin
               exp_byte = exp_q.pop_front();
               if (out_data !== exp_byte) begin
                  err_cnt++;
                  $display("ERROR at %0t: byte %0d is %02h, expected %02h",
                           $time, bytes_out - 1, out_data, exp_byte);
               end
            end
         end
         // running limits on both credit loops
         if (bytes_out > out_credit_cnt) begin
            err_cnt++;
            $display("ERROR at %0t: %0d bytes sent on %0d consumer credits",
                     $time, bytes_out, out_credit_cnt);
         end
         if (in_credit_cnt > DEPTH_WORDS + bytes_out / `FIFO_LANES) begin
            err_cnt++;
            $display("ERROR at %0t: %0d in_credit pulses with %0d words delivered",
                     $time, in_credit_cnt, bytes_out / `FIFO_LANES);
         end
      end
   end

   task automatic check_count(input string what, input int got, input int exp);
      check_cnt++;
      if (got != exp) begin
         err_cnt++;
         $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      tests_done++;
      $display("%0t: %s finished with %0d errors", $time, name, err_cnt - test_err_base);
      test_err_base = err_cnt;
   endtask

endmodule

// File: verif/fifo_asserts.sv
`timescale 1ns/100ps
`include "fifo_consts.svh"

module fifo_asserts (
   input logic clk,
   input logic reset,
   input logic w_en,
   input logic r_en,
   input logic in_credit,
   input logic out_credit
);

   localparam int DEPTH_WORDS = 1 << `FIFO_WADDR_W;

   int fail_cnt = 0;

   // bytes written and not yet read, seen at the strobes
   int held_bytes;
   // consumer credits not yet spent on a read
   int cons_credits;
   // reads so far, low bits give the lane
   int rd_bytes;
   // producer credits owed and not yet pulsed
   int owed;

   always @(posedge clk) begin
      if (reset) begin
         held_bytes   <= 0;
         cons_credits <= 0;
         rd_bytes     <= 0;
         owed         <= DEPTH_WORDS;
      end else begin
         held_bytes   <= held_bytes + (w_en ? `FIFO_LANES : 0) - (r_en ? 1 : 0);
         cons_credits <= cons_credits + (out_credit ? 1 : 0) - (r_en ? 1 : 0);
         if (r_en) begin
            rd_bytes <= rd_bytes + 1;
         end
         owed <= owed - (in_credit ? 1 : 0) +
                 ((r_en && (rd_bytes % `FIFO_LANES) == `FIFO_LANES - 1) ? 1 : 0);
      end
   end

   a_read_has_data : assert property (
      @(posedge clk) disable iff (reset) r_en |-> (held_bytes != 0)
   ) else begin
      fail_cnt++;
      $error("read issued with no byte waiting");
   end

   a_read_has_credit : assert property (
      @(posedge clk) disable iff (reset) r_en |-> (cons_credits != 0)
   ) else begin
      fail_cnt++;
      $error("read issued with no consumer credit");
   end

   // never owe the producer more than the whole RAM
   a_pend_limit : assert property (
      @(posedge clk) disable iff (reset) owed <= DEPTH_WORDS
   ) else begin
      fail_cnt++;
      $error("pending in-credit count above depth");
   end

endmodule

bind credit_fifo_ctrl fifo_asserts u_asserts (
   .clk        (clk),
   .reset      (reset),
   .w_en       (in_valid),
   .r_en       (rd_go),
   .in_credit  (in_credit),
   .out_credit (out_credit)
);

// File: verif/tb_top.sv
`timescale 1ns/100ps
`include "fifo_consts.svh"

module tb_top import fifo_pkg::*; ();

   localparam int DEPTH_WORDS = 1 << `FIFO_WADDR_W;

   logic  clk;
   logic  reset;
   logic  in_valid;
   word_t in_data;
   logic  in_credit;
   logic  out_valid;
   byte_t out_data;
   logic  out_credit;

   integer seed;
   int     cycle;
   int     prod_left;
   int     prod_credits;
   int     prod_rate;
   bit     cons_hold;
   int     cons_max_delay;
   int     due;
   int     ret_q [$];
   bit     timed_out;
   int     wait_n;
   int     total_errors;

   tb_clkgen clkgen (.clk(clk), .reset(reset));

   width_down_fifo dut (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit)
   );

   tb_checker chk (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_data   (out_data)
   );

   // producer and consumer models, driven just after each edge
   always @(posedge clk) begin
      #1;
      in_valid   = 1'b0;
      out_credit = 1'b0;
      if (!reset) begin
         if (in_credit) begin
            prod_credits++;
         end
         if (prod_left > 0 && prod_credits > 0 &&
             ($unsigned($random(seed)) % 100) < prod_rate) begin
            in_data  = $random(seed);
            in_valid = 1'b1;
            prod_credits--;
            prod_left--;
         end
         // one credit back per byte, 0 to 3 cycles later
         if (out_valid) begin
            due = cycle;
            if (cons_max_delay > 0) begin
               due = cycle + ($unsigned($random(seed)) % (cons_max_delay + 1));
            end
            if (ret_q.size() > 0 && ret_q[$] >= due) begin
               due = ret_q[$] + 1;
            end
            ret_q.push_back(due);
         end
         if (!cons_hold && ret_q.size() > 0 && ret_q[0] <= cycle) begin
            void'(ret_q.pop_front());
            out_credit = 1'b1;
         end
         cycle++;
      end
   end

   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   task automatic note_timeout(input string what);
      timed_out = 1'b1;
      $display("timed out waiting for %s", what);
   endtask

   function automatic bit drained();
      return prod_left == 0 && !in_valid && chk.bytes_out == `FIFO_LANES * chk.words_in;
   endfunction

   function automatic bit credits_settled();
      return chk.in_credit_cnt == DEPTH_WORDS + chk.bytes_out / `FIFO_LANES;
   endfunction

   task automatic wait_drained(input int limit);
      wait_n = 0;
      while (!drained() && wait_n < limit) begin
         tick();
         wait_n++;
      end
      if (!drained()) begin
         note_timeout("the buffer to drain");
      end
   endtask

   task automatic wait_settled(input int limit);
      wait_n = 0;
      while (!credits_settled() && wait_n < limit) begin
         tick();
         wait_n++;
      end
      if (!credits_settled()) begin
         note_timeout("in_credit to match the words delivered");
      end
   endtask

   task automatic reset_credits_test();
      wait_n = 0;
      while (chk.in_credit_cnt < DEPTH_WORDS && wait_n < 100) begin
         tick();
         wait_n++;
      end
      if (chk.in_credit_cnt < DEPTH_WORDS) begin
         note_timeout("the credits owed after reset");
         return;
      end
      // quiet window, no further pulses expected
      repeat (20) tick();
      chk.check_count("in_credit pulses after reset", chk.in_credit_cnt, DEPTH_WORDS);
      chk.check_count("bytes out with no traffic", chk.bytes_out, 0);
      chk.end_test("reset credits");
   endtask

   task automatic lane_order_test();
      cons_max_delay = 0;
      prod_rate      = 100;
      prod_left      = 12;
      wait_drained(1000);
      if (timed_out) begin
         return;
      end
      wait_settled(100);
      if (!timed_out) begin
         chk.end_test("lane order");
      end
   endtask

   task automatic consumer_stall_test();
      int credits_before;
      int bytes_before;
      cons_hold = 1'b1;
      prod_rate = 100;
      prod_left = 24;
      wait_n    = 0;
      while (chk.words_in - chk.bytes_out / `FIFO_LANES < DEPTH_WORDS && wait_n < 500) begin
         tick();
         wait_n++;
      end
      if (chk.words_in - chk.bytes_out / `FIFO_LANES < DEPTH_WORDS) begin
         note_timeout("the buffer to fill");
         return;
      end
      credits_before = chk.in_credit_cnt;
      bytes_before   = chk.bytes_out;
      repeat (20) tick();
      chk.check_count("in_credit pulses while full", chk.in_credit_cnt, credits_before);
      chk.check_count("bytes out with credits held", chk.bytes_out, bytes_before);
      cons_hold = 1'b0;
      wait_drained(2000);
      if (!timed_out) begin
         chk.end_test("consumer stall");
      end
   endtask

   task automatic credit_return_test();
      wait_settled(200);
      if (timed_out) begin
         return;
      end
      repeat (10) tick();
      chk.check_count("in_credit pulses against words delivered", chk.in_credit_cnt,
                      DEPTH_WORDS + chk.bytes_out / `FIFO_LANES);
      chk.end_test("credit return");
   endtask

   task automatic random_mix_test();
      prod_rate      = 60;
      cons_max_delay = 3;
      prod_left      = 300;
      wait_drained(20000);
      if (timed_out) begin
         return;
      end
      wait_settled(200);
      if (!timed_out) begin
         chk.end_test("random mix");
      end
   endtask

   initial begin
      seed           = 32'h4fadc788;
      in_valid       = 1'b0;
      in_data        = '0;
      out_credit     = 1'b0;
      cycle          = 0;
      prod_left      = 0;
      prod_credits   = 0;
      prod_rate      = 100;
      cons_hold      = 1'b0;
      cons_max_delay = 0;
      timed_out      = 1'b0;
      // consumer grants its first credits one per cycle
      repeat (`FIFO_OUT_CREDIT_MAX) ret_q.push_back(0);
      wait_n = 0;
      while (reset !== 1'b0 && wait_n < 20) begin
         tick();
         wait_n++;
      end
      if (reset !== 1'b0) begin
         note_timeout("reset to clear");
      end
      if (!timed_out) reset_credits_test();
      if (!timed_out) lane_order_test();
      if (!timed_out) consumer_stall_test();
      if (!timed_out) credit_return_test();
      if (!timed_out) random_mix_test();
      total_errors = chk.err_cnt + dut.u_ctrl.u_asserts.fail_cnt;
      $display("tests %0d, checks %0d, bytes %0d, errors %0d",
               chk.tests_done, chk.check_cnt, chk.bytes_out, total_errors);
      if (timed_out || total_errors != 0) begin
         $display("test failed");
      end else begin
         $display("test passed");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+verilog
verilog/fifo_pkg.sv
verilog/ram_port_if.sv
verilog/ram_2p.sv
verilog/ram_2p_asym.sv
verilog/credit_fifo_ctrl.sv
verilog/width_down_fifo.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/fifo_asserts.sv
verif/tb_top.sv
